/* src/rvCorePkg.sv */
package rvCorePkg;

    typedef logic [63:0] xlenWord;
    typedef logic [31:0] instrWord;
    typedef logic [4:0]  regIndex;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluOr  = 2'd3
    } aluOp;

    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    localparam logic [2:0] funct3Double = 3'b011; // ld and sd
    localparam logic [2:0] funct3Eq     = 3'b000; // beq, add, sub, addi

    typedef struct packed {
        regIndex rs1;
        regIndex rs2;
        regIndex rd;
        xlenWord immediate;
        aluOp    op;
        logic    useImmediate;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    branch;
        logic    invalidOp;
    } decodedInstr;

    // One retired instruction as seen at the top
    typedef struct packed {
        logic    regWrite;
        regIndex rd;
        xlenWord writeData;
        logic    memWrite;
        xlenWord memAddr;
        xlenWord storeData;
        logic    invalidOp;
        logic    invalidMemAddr;
    } commitRecord;

endpackage

/* src/instructionDecode.sv */
`timescale 1ns/1ps

module instructionDecode (
    input  logic                   reset,
    input  rvCorePkg::instrWord    instruction,
    output rvCorePkg::decodedInstr decoded
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rvCorePkg::xlenWord immI;
    rvCorePkg::xlenWord immS;
    rvCorePkg::xlenWord immB;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    assign immI = {{52{instruction[31]}}, instruction[31:20]};
    assign immS = {{52{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{51{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};

    always_comb begin
        decoded = '0;
        decoded.rs1 = instruction[19:15];
        decoded.rs2 = instruction[24:20];
        decoded.rd = instruction[11:7];
        decoded.op = rvCorePkg::aluAdd;
        case (opcode)
            rvCorePkg::opReg: begin
                decoded.regWrite = 1'b1;
                if (funct3 == 3'b000 && funct7 == 7'b0000000)
                    decoded.op = rvCorePkg::aluAdd;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000)
                    decoded.op = rvCorePkg::aluSub;
                else if (funct3 == 3'b111 && funct7 == 7'b0000000)
                    decoded.op = rvCorePkg::aluAnd;
                else if (funct3 == 3'b110 && funct7 == 7'b0000000)
                    decoded.op = rvCorePkg::aluOr;
                else
                    decoded.invalidOp = 1'b1;
            end
            rvCorePkg::opImm: begin
                decoded.regWrite = 1'b1;
                decoded.useImmediate = 1'b1;
                decoded.immediate = immI;
                decoded.invalidOp = (funct3 != rvCorePkg::funct3Eq); // addi only
            end
            rvCorePkg::opLoad: begin
                decoded.regWrite = 1'b1;
                decoded.memRead = 1'b1;
                decoded.useImmediate = 1'b1;
                decoded.immediate = immI;
                decoded.invalidOp = (funct3 != rvCorePkg::funct3Double);
            end
            rvCorePkg::opStore: begin
                decoded.memWrite = 1'b1;
                decoded.useImmediate = 1'b1;
                decoded.immediate = immS;
                decoded.invalidOp = (funct3 != rvCorePkg::funct3Double);
            end
            rvCorePkg::opBranch: begin
                decoded.branch = 1'b1;
                decoded.op = rvCorePkg::aluSub;
                decoded.immediate = immB;
                decoded.invalidOp = (funct3 != rvCorePkg::funct3Eq); // beq only
            end
            default: decoded.invalidOp = 1'b1;
        endcase
        if (decoded.invalidOp || reset) begin // Turns into a no-op
            decoded.regWrite = 1'b0;
            decoded.memRead = 1'b0;
            decoded.memWrite = 1'b0;
            decoded.branch = 1'b0;
        end
    end

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic               clock,
    input  logic               reset,
    input  rvCorePkg::regIndex readAddrA,
    input  rvCorePkg::regIndex readAddrB,
    output rvCorePkg::xlenWord readDataA,
    output rvCorePkg::xlenWord readDataB,
    input  logic               writeEnable,
    input  rvCorePkg::regIndex writeAddr,
    input  rvCorePkg::xlenWord writeData
);

    rvCorePkg::xlenWord regs [32];

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin // x0 stays zero
            regs[writeAddr] <= writeData;
        end
    end

    // x0 must read as zero whatever was retired before
    assert property (@(posedge clock) disable iff (reset)
        (readAddrA == '0) |-> (readDataA == '0));

    assert property (@(posedge clock) disable iff (reset)
        (readAddrB == '0) |-> (readDataB == '0));

endmodule

/* src/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  rvCorePkg::decodedInstr decoded,
    input  rvCorePkg::xlenWord     rs1Value,
    input  rvCorePkg::xlenWord     rs2Value,
    output rvCorePkg::xlenWord     result,
    output logic                   taken
);

    rvCorePkg::xlenWord operandB;

    // Immediate for addi, ld and sd
    assign operandB = decoded.useImmediate ? decoded.immediate : rs2Value;

    always_comb begin
        case (decoded.op)
            rvCorePkg::aluAdd: result = rs1Value + operandB;
            rvCorePkg::aluSub: result = rs1Value - operandB;
            rvCorePkg::aluAnd: result = rs1Value & operandB;
            rvCorePkg::aluOr:  result = rs1Value | operandB;
            default:           result = '0;
        endcase
    end

    // beq compares the register pair, not the immediate
    assign taken = decoded.branch && (rs1Value == rs2Value);

endmodule

/* src/programCounter.sv */
`timescale 1ns/1ps

module programCounter (
    input  logic               clock,
    input  logic               reset,
    input  rvCorePkg::xlenWord immediate,
    input  logic               taken,
    output rvCorePkg::xlenWord pc
);

    rvCorePkg::xlenWord nextPc;

    assign nextPc = taken ? pc + immediate : pc + 64'd4;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // Branch targets must keep word alignment
    assert property (@(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

/* src/memoryAccess.sv */
`timescale 1ns/1ps

module memoryAccess #(
    parameter int memWords = 1024
) (
    input  logic                   clock,
    input  rvCorePkg::decodedInstr decoded,
    input  rvCorePkg::xlenWord     address,
    input  rvCorePkg::xlenWord     storeData,
    input  rvCorePkg::xlenWord     aluResult,
    output rvCorePkg::xlenWord     writeBackData,
    output logic                   invalidMemAddr
);

    localparam int indexBits = (memWords > 1) ? $clog2(memWords) : 1;

    rvCorePkg::xlenWord mem [memWords];
    logic [indexBits-1:0] wordIndex;
    logic addrValid;
    logic memWriteEnable;
    rvCorePkg::xlenWord readWord;

    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = rvCorePkg::xlenWord'(i + 1);
        end
    end

    assign addrValid = (address[2:0] == 3'b000) &&
                       (address < (rvCorePkg::xlenWord'(memWords) << 3));
    assign wordIndex = address[3 +: indexBits];
    assign invalidMemAddr = (decoded.memRead || decoded.memWrite) && !addrValid;
    assign memWriteEnable = decoded.memWrite && addrValid;

    assign readWord = addrValid ? mem[wordIndex] : '0;
    assign writeBackData = decoded.memRead ? readWord : aluResult; // Load data or ALU result

    always_ff @(posedge clock) begin
        if (memWriteEnable) begin
            mem[wordIndex] <= storeData;
        end
    end

endmodule

/* src/datapath.sv */
`timescale 1ns/1ps

module datapath #(
    parameter int memWords = 1024
) (
    input  logic                   clock,
    input  logic                   reset,
    input  rvCorePkg::instrWord    instruction,
    output rvCorePkg::xlenWord     instrAddr,
    output rvCorePkg::commitRecord commit
);

    rvCorePkg::decodedInstr decoded;
    rvCorePkg::xlenWord rs1Value;
    rvCorePkg::xlenWord rs2Value;
    rvCorePkg::xlenWord aluResult;
    rvCorePkg::xlenWord writeBackData;
    logic taken;
    logic invalidMemAddr;
    logic regWriteEnable;

    // Bad load address or bad encoding blocks write-back
    assign regWriteEnable = decoded.regWrite && !decoded.invalidOp && !invalidMemAddr;

    instructionDecode u_decode (
        .reset       (reset),
        .instruction (instruction),
        .decoded     (decoded)
    );

    registerFile u_registers (
        .clock       (clock),
        .reset       (reset),
        .readAddrA   (decoded.rs1),
        .readAddrB   (decoded.rs2),
        .readDataA   (rs1Value),
        .readDataB   (rs2Value),
        .writeEnable (regWriteEnable),
        .writeAddr   (decoded.rd),
        .writeData   (writeBackData)
    );

    aluUnit u_alu (
        .decoded  (decoded),
        .rs1Value (rs1Value),
        .rs2Value (rs2Value),
        .result   (aluResult),
        .taken    (taken)
    );

    programCounter u_pc (
        .clock     (clock),
        .reset     (reset),
        .immediate (decoded.immediate),
        .taken     (taken),
        .pc        (instrAddr)
    );

    memoryAccess #(.memWords(memWords)) u_memory (
        .clock          (clock),
        .decoded        (decoded),
        .address        (aluResult),
        .storeData      (rs2Value),
        .aluResult      (aluResult),
        .writeBackData  (writeBackData),
        .invalidMemAddr (invalidMemAddr)
    );

    always_comb begin
        commit.regWrite = regWriteEnable && (decoded.rd != '0); // x0 writes are dropped
        commit.rd = decoded.rd;
        commit.writeData = writeBackData;
        commit.memWrite = decoded.memWrite && !decoded.invalidOp && !invalidMemAddr;
        commit.memAddr = aluResult;
        commit.storeData = rs2Value;
        commit.invalidOp = decoded.invalidOp;
        commit.invalidMemAddr = invalidMemAddr;
    end

endmodule

/* tests/commitChecker.sv */
`timescale 1ns/1ps

module commitChecker #(
    parameter int memWords = 1024
) (
    input  logic                   clock,
    input  logic                   reset,
    input  rvCorePkg::instrWord    instruction,
    input  rvCorePkg::xlenWord     instrAddr,
    input  rvCorePkg::commitRecord commit,
    output int                     errorCount,
    output int                     checkCount
);

    rvCorePkg::xlenWord modelPc;
    rvCorePkg::xlenWord modelRegs [32];
    rvCorePkg::xlenWord modelMem [memWords];

    initial begin
        errorCount = 0;
        checkCount = 0;
        modelPc = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < memWords; i++) begin
            modelMem[i] = 64'(i + 1); // Word i holds i plus 1
        end
    end

    task automatic compareWord(string name, logic [63:0] expected, logic [63:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareFlag(string name, logic expected, logic actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkReset();
        compareWord("instrAddr", 64'd0, instrAddr);
        compareFlag("commit.regWrite", 1'b0, commit.regWrite);
        compareFlag("commit.memWrite", 1'b0, commit.memWrite);
        modelPc = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
    endtask

    task automatic checkAndStep();
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rvCorePkg::xlenWord a;
        rvCorePkg::xlenWord b;
        rvCorePkg::xlenWord immI;
        rvCorePkg::xlenWord immS;
        rvCorePkg::xlenWord immB;
        rvCorePkg::xlenWord result;
        rvCorePkg::xlenWord address;
        rvCorePkg::xlenWord nextPc;
        logic legal;
        logic writesReg;
        logic isLoad;
        logic isStore;
        logic isBranch;
        logic badAddr;
        logic memFlag;
        logic expRegWrite;
        logic expMemWrite;

        opcode = instruction[6:0];
        funct3 = instruction[14:12];
        funct7 = instruction[31:25];
        rd = instruction[11:7];
        rs1 = instruction[19:15];
        rs2 = instruction[24:20];
        a = modelRegs[rs1];
        b = modelRegs[rs2];
        immI = {{52{instruction[31]}}, instruction[31:20]};
        immS = {{52{instruction[31]}}, instruction[31:25], instruction[11:7]};
        immB = {{51{instruction[31]}}, instruction[31], instruction[7],
                instruction[30:25], instruction[11:8], 1'b0};
        legal = 1'b0;
        writesReg = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        isBranch = 1'b0;
        result = '0;
        address = '0;

        case (opcode)
            rvCorePkg::opReg: begin
                legal = 1'b1;
                writesReg = 1'b1;
                if (funct7 == 7'b0000000 && funct3 == 3'b000)
                    result = a + b;
                else if (funct7 == 7'b0100000 && funct3 == 3'b000)
                    result = a - b;
                else if (funct7 == 7'b0000000 && funct3 == 3'b111)
                    result = a & b;
                else if (funct7 == 7'b0000000 && funct3 == 3'b110)
                    result = a | b;
                else
                    legal = 1'b0;
            end
            rvCorePkg::opImm: begin
                legal = (funct3 == 3'b000);
                writesReg = 1'b1;
                result = a + immI;
            end
            rvCorePkg::opLoad: begin
                legal = (funct3 == 3'b011);
                writesReg = 1'b1;
                isLoad = 1'b1;
                address = a + immI;
            end
            rvCorePkg::opStore: begin
                legal = (funct3 == 3'b011);
                isStore = 1'b1;
                address = a + immS;
            end
            rvCorePkg::opBranch: begin
                legal = (funct3 == 3'b000);
                isBranch = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        badAddr = (address[2:0] != 3'b000) || (address >= 64'(memWords) * 64'd8);
        if (legal && isLoad && !badAddr) begin
            result = modelMem[int'(address >> 3)];
        end
        memFlag = legal && (isLoad || isStore) && badAddr;
        expRegWrite = legal && writesReg && !memFlag && (rd != 5'd0);
        expMemWrite = legal && isStore && !badAddr;
        nextPc = (legal && isBranch && a == b) ? modelPc + immB : modelPc + 64'd4;

        compareWord("instrAddr", modelPc, instrAddr);
        compareFlag("commit.invalidOp", !legal, commit.invalidOp);
        compareFlag("commit.invalidMemAddr", memFlag, commit.invalidMemAddr);
        compareFlag("commit.regWrite", expRegWrite, commit.regWrite);
        compareFlag("commit.memWrite", expMemWrite, commit.memWrite);
        if (expRegWrite) begin
            compareWord("commit.rd", 64'(rd), 64'(commit.rd));
            compareWord("commit.writeData", result, commit.writeData);
        end
        if (legal && isStore) begin // Bad stores still report the address
            compareWord("commit.memAddr", address, commit.memAddr);
            compareWord("commit.storeData", b, commit.storeData);
        end

        if (expRegWrite) begin
            modelRegs[rd] = result;
        end
        if (expMemWrite) begin
            modelMem[int'(address >> 3)] = b;
        end
        modelPc = nextPc;
    endtask

    // Mid-cycle, inputs and commit are settled
    always @(negedge clock) begin
        if (reset) begin
            checkReset();
        end else begin
            checkAndStep();
        end
    end

endmodule

/* tests/datapathTb.sv */
`timescale 1ns/1ps

module datapathTb;

    localparam int memWords = 1024;
    localparam int romDepth = 256;
    localparam int numCycles = 3000;
    localparam int clockPeriod = 100;
    localparam int watchdogCycles = numCycles + 100;

    logic clock;
    logic reset;
    rvCorePkg::instrWord instruction;
    rvCorePkg::xlenWord instrAddr;
    rvCorePkg::commitRecord commit;
    int errorCount;
    int checkCount;
    int seed;
    rvCorePkg::instrWord rom [romDepth];

    datapath #(.memWords(memWords)) u_datapath (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .instrAddr   (instrAddr),
        .commit      (commit)
    );

    commitChecker #(.memWords(memWords)) u_checker (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .instrAddr   (instrAddr),
        .commit      (commit),
        .errorCount  (errorCount),
        .checkCount  (checkCount)
    );

    function automatic rvCorePkg::instrWord encodeR(logic [6:0] funct7, logic [4:0] rs2,
                                                    logic [4:0] rs1, logic [2:0] funct3,
                                                    logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, rvCorePkg::opReg};
    endfunction

    function automatic rvCorePkg::instrWord encodeI(logic [6:0] opcode, logic [11:0] imm,
                                                    logic [4:0] rs1, logic [2:0] funct3,
                                                    logic [4:0] rd);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic rvCorePkg::instrWord encodeS(logic [11:0] imm, logic [4:0] rs2,
                                                    logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, rvCorePkg::funct3Double, imm[4:0], rvCorePkg::opStore};
    endfunction

    function automatic rvCorePkg::instrWord encodeB(logic [12:0] offset, logic [4:0] rs2,
                                                    logic [4:0] rs1);
        return {offset[12], offset[10:5], rs2, rs1, rvCorePkg::funct3Eq,
                offset[4:1], offset[11], rvCorePkg::opBranch};
    endfunction

    task automatic fillRom();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] offset;
        logic [12:0] branchOffset;
        int words;
        for (int i = 0; i < romDepth; i++) begin
            r = $random(seed);
            s = $random(seed);
            rd = {2'b00, r[6:4]}; // x0 to x7 only
            rs1 = {2'b00, r[9:7]};
            rs2 = {2'b00, r[12:10]};
            offset = {1'b0, s[7:0], 3'b000};
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    case (r[14:13])
                        2'd0: rom[i] = encodeR(7'b0000000, rs2, rs1, 3'b000, rd);
                        2'd1: rom[i] = encodeR(7'b0100000, rs2, rs1, 3'b000, rd);
                        2'd2: rom[i] = encodeR(7'b0000000, rs2, rs1, 3'b111, rd);
                        default: rom[i] = encodeR(7'b0000000, rs2, rs1, 3'b110, rd);
                    endcase
                end
                4'd4, 4'd5, 4'd6: begin
                    rom[i] = encodeI(rvCorePkg::opImm, s[11:0], rs1, rvCorePkg::funct3Eq, rd);
                end
                4'd7, 4'd8: begin
                    rom[i] = encodeI(rvCorePkg::opLoad, offset, 5'd0,
                                     rvCorePkg::funct3Double, rd);
                end
                4'd9, 4'd10: rom[i] = encodeS(offset, rs2, 5'd0);
                4'd11, 4'd12: begin // Random base and offset give many bad addresses
                    if (s[31])
                        rom[i] = encodeI(rvCorePkg::opLoad, s[23:12], rs1,
                                         rvCorePkg::funct3Double, rd);
                    else
                        rom[i] = encodeS(s[23:12], rs2, rs1);
                end
                4'd13, 4'd14: begin
                    words = int'(s[3:0]) - 4;
                    if (words == 0)
                        words = 5;
                    branchOffset = 13'(words * 4);
                    // Backward ones compare two registers
                    rom[i] = encodeB(branchOffset, (s[4] && words > 0) ? rs1 : rs2, rs1);
                end
                default: rom[i] = s; // Mostly unsupported encodings
            endcase
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    initial begin
        seed = 41464;
        reset = 1'b1;
        fillRom();
        instruction = rom[0];
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
        instruction = rom[instrAddr[9:2]];
        for (int cycle = 2; cycle < numCycles; cycle++) begin
            @(posedge clock);
            #1 instruction = rom[instrAddr[9:2]]; // ROM index is PC/4 mod 256
        end
        @(negedge clock);
        #1;
        $display("Run complete: %0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Timeout: the run did not end within %0d cycles", watchdogCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* datapath.f */
src/rvCorePkg.sv
src/instructionDecode.sv
src/registerFile.sv
src/aluUnit.sv
src/programCounter.sv
src/memoryAccess.sv
src/datapath.sv
tests/commitChecker.sv
tests/datapathTb.sv

/* Makefile */
TOP = datapathTb

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f datapath.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: help test clean
